// File: Makefile
sim := obj_dir/Vrs_erasure_codec_tb

.PHONY: run clean

run: $(sim)
	@out=$$(./$(sim)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^sim passed$$"

$(sim): compile.f $(wildcard source/*.sv) test/rs_erasure_codec_tb.sv
	verilator --binary --timing -j 0 -f compile.f --top-module rs_erasure_codec_tb

clean:
	rm -rf obj_dir

// File: compile.f
source/gf_pkg.sv
source/fec_pkg.sv
source/gf_mat_vec_mul.sv
source/rs_encode.sv
source/rs_decode_h_select.sv
source/rs_decode.sv
source/rs_erasure_codec.sv
test/rs_erasure_codec_tb.sv

// File: source/fec_pkg.sv
`default_nettype none

package fec_pkg;

    import gf_pkg::*;

    // ==================================================
    // Code sizes and types
    // ==================================================

    localparam int rs_k  = 4;
    localparam int rs_n  = 6;
    localparam int rs_2t = 2;
    localparam int num_h = 15;

    typedef gf_sym_t [rs_k-1:0]           msg_t;
    // Message in symbols 0..3, parity in 4..5
    typedef gf_sym_t [rs_n-1:0]           cw_t;
    // Indexed as [row][col]
    typedef gf_sym_t [rs_k-1:0][rs_k-1:0] mat_t;
    typedef logic [3:0]                   h_idx_t;
    typedef logic [rs_n-1:0]              erase_vec_t;

    typedef struct packed {
        msg_t msg;
    } enc_in_t;

    typedef struct packed {
        cw_t cw;
    } enc_out_t;

    typedef struct packed {
        cw_t    cw;
        h_idx_t h_idx;
    } dec_in_t;

    typedef struct packed {
        msg_t surv;
        mat_t mat;
    } hsel_t;

    typedef struct packed {
        msg_t msg;
    } dec_out_t;

    // ==================================================
    // Code tables
    // ==================================================

    // Parity 4 is the plain sum, parity 5 weights symbol i by alpha^i
    localparam msg_t par_gen [rs_2t] = '{16'h1111, 16'h8421};

    // Erased pair per pattern, lexicographic order
    localparam erase_vec_t erase_lut [num_h] = '{
        6'b000011, 6'b000101, 6'b001001, 6'b010001, 6'b100001,
        6'b000110, 6'b001010, 6'b010010, 6'b100010,
        6'b001100, 6'b010100, 6'b100100,
        6'b011000, 6'b101000,
        6'b110000
    };

    // Inverse of the surviving generator rows
    // Row 3 first, each row written col 3 down to col 0
    localparam mat_t rec_mat [num_h] = '{
        {16'h0010, 16'h0001, 16'hEE73, 16'hEF62},  // (0,1)
        {16'h0010, 16'hBBCE, 16'h0001, 16'hBADF},  // (0,2)
        {16'h22A6, 16'h0010, 16'h0001, 16'h23B7},  // (0,3)
        {16'h0100, 16'h0010, 16'h0001, 16'h1842},  // (0,4)
        {16'h0100, 16'h0010, 16'h0001, 16'h1111},  // (0,5)
        {16'h0010, 16'h7E39, 16'h7F28, 16'h0001},  // (1,2)
        {16'hCBE7, 16'h0010, 16'hCAF6, 16'h0001},  // (1,3)
        {16'h0100, 16'h0010, 16'h9429, 16'h0001},  // (1,4)
        {16'h0100, 16'h0010, 16'h1111, 16'h0001},  // (1,5)
        {16'hAE94, 16'hAF85, 16'h0010, 16'h0001},  // (2,3)
        {16'h0100, 16'hD29D, 16'h0010, 16'h0001},  // (2,4)
        {16'h0100, 16'h1111, 16'h0010, 16'h0001},  // (2,5)
        {16'hF9DF, 16'h0100, 16'h0010, 16'h0001},  // (3,4)
        {16'h1111, 16'h0100, 16'h0010, 16'h0001},  // (3,5)
        {16'h1000, 16'h0100, 16'h0010, 16'h0001}   // (4,5) parity lost only
    };

endpackage

`default_nettype wire

// File: source/gf_mat_vec_mul.sv
`timescale 1ns/1ps
`default_nettype none

module gf_mat_vec_mul (
    input  wire fec_pkg::mat_t mat,
    input  wire fec_pkg::msg_t vec,
    output fec_pkg::msg_t      prod
);

    import gf_pkg::*;
    import fec_pkg::*;

    // Row-by-vector dot products over the field
    always_comb begin
        gf_sym_t acc;
        for (int r = 0; r < rs_k; r++) begin
            acc = '0;
            for (int c = 0; c < rs_k; c++) begin
                acc = gf_add(acc, gf_mul(mat[r][c], vec[c]));
            end
            prod[r] = acc;
        end
    end

endmodule

`default_nettype wire

// File: source/gf_pkg.sv
`default_nettype none

package gf_pkg;

    // ==================================================
    // GF(2^4) arithmetic, field polynomial x^4+x+1
    // ==================================================

    localparam int gf_m = 4;

    // Reduction term for x^4 (x+1)
    localparam logic [gf_m-1:0] gf_poly = 4'h3;

    typedef logic [gf_m-1:0] gf_sym_t;

    // Shift-and-add multiply with reduction on every shift
    function automatic gf_sym_t gf_mul(input gf_sym_t a, input gf_sym_t b);
        gf_sym_t acc;
        gf_sym_t sh;
        acc = '0;
        sh  = a;
        for (int i = 0; i < gf_m; i++) begin
            if (b[i]) begin
                acc = acc ^ sh;
            end
            sh = sh[gf_m-1] ? ((sh << 1) ^ gf_poly) : (sh << 1);
        end
        return acc;
    endfunction

    // Addition in characteristic 2
    function automatic gf_sym_t gf_add(input gf_sym_t a, input gf_sym_t b);
        return a ^ b;
    endfunction

endpackage

`default_nettype wire

// File: source/rs_decode.sv
`timescale 1ns/1ps
`default_nettype none

module rs_decode (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire fec_pkg::hsel_t in_data,
    input  wire                 in_valid,
    output logic                in_ready,
    output fec_pkg::dec_out_t   out_data,
    output logic                out_valid,
    input  wire                 out_ready
);

    import fec_pkg::*;

    msg_t msg_rec;

    // ==================================================
    // Message recovery
    // ==================================================

    // Recovery matrix times survivors gives the message back
    gf_mat_vec_mul u_rec_mul (
        .mat  (in_data.mat),
        .vec  (in_data.surv),
        .prod (msg_rec)
    );

    // ==================================================
    // Output register
    // ==================================================

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    // Payload only, held while stalled
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data.msg <= msg_rec;
        end
    end

endmodule

`default_nettype wire

// File: source/rs_decode_h_select.sv
`timescale 1ns/1ps
`default_nettype none

module rs_decode_h_select (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire fec_pkg::dec_in_t in_data,
    input  wire                   in_valid,
    output logic                  in_ready,
    output fec_pkg::hsel_t        out_data,
    output logic                  out_valid,
    input  wire                   out_ready
);

    import fec_pkg::*;

    erase_vec_t erase_vec;
    msg_t       surv;
    mat_t       mat_sel;

    // ==================================================
    // Survivor compaction
    // ==================================================

    assign erase_vec = erase_lut[in_data.h_idx];
    assign mat_sel   = rec_mat[in_data.h_idx];

    // Non-erased symbols packed down in ascending position order
    always_comb begin
        int k;
        surv = '0;
        k    = 0;
        for (int i = 0; i < rs_n; i++) begin
            if (!erase_vec[i] && (k < rs_k)) begin
                surv[k] = in_data.cw[i];
                k++;
            end
        end
    end

    // ==================================================
    // Output register
    // ==================================================

    // Free slot, or the held item leaves this cycle
    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data.surv <= surv;
            out_data.mat  <= mat_sel;
        end
    end

endmodule

`default_nettype wire

// File: source/rs_encode.sv
`timescale 1ns/1ps
`default_nettype none

module rs_encode (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire fec_pkg::enc_in_t in_data,
    input  wire                   in_valid,
    output logic                  in_ready,
    output fec_pkg::enc_out_t     out_data,
    output logic                  out_valid,
    input  wire                   out_ready
);

    import fec_pkg::*;

    mat_t par_mat;
    msg_t par_prod;
    cw_t  cw_next;

    // ==================================================
    // Parity product
    // ==================================================

    // Generator rows in the low rows, upper rows zero
    always_comb begin
        par_mat = '0;
        for (int j = 0; j < rs_2t; j++) begin
            par_mat[j] = par_gen[j];
        end
    end

    gf_mat_vec_mul u_par_mul (
        .mat  (par_mat),
        .vec  (in_data.msg),
        .prod (par_prod)
    );

    assign cw_next = {par_prod[rs_2t-1:0], in_data.msg};

    // ==================================================
    // Output register
    // ==================================================

    assign in_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            out_data.cw <= cw_next;
        end
    end

endmodule

`default_nettype wire

// File: source/rs_erasure_codec.sv
`timescale 1ns/1ps
`default_nettype none

module rs_erasure_codec (
    input  wire                    clk,
    input  wire                    arst_n,

    input  wire fec_pkg::enc_in_t  enc_in,
    input  wire                    enc_in_valid,
    output logic                   enc_in_ready,
    output fec_pkg::enc_out_t      enc_out,
    output logic                   enc_out_valid,
    input  wire                    enc_out_ready,

    input  wire fec_pkg::dec_in_t  dec_in,
    input  wire                    dec_in_valid,
    output logic                   dec_in_ready,
    output fec_pkg::dec_out_t      dec_out,
    output logic                   dec_out_valid,
    input  wire                    dec_out_ready
);

    import fec_pkg::*;

    hsel_t hsel_data;
    logic  hsel_valid;
    logic  hsel_ready;

    // ==================================================
    // Encode path
    // ==================================================

    rs_encode u_encode (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (enc_in),
        .in_valid  (enc_in_valid),
        .in_ready  (enc_in_ready),
        .out_data  (enc_out),
        .out_valid (enc_out_valid),
        .out_ready (enc_out_ready)
    );

    // ==================================================
    // Decode path, two stages
    // ==================================================

    rs_decode_h_select u_h_select (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (dec_in),
        .in_valid  (dec_in_valid),
        .in_ready  (dec_in_ready),
        .out_data  (hsel_data),
        .out_valid (hsel_valid),
        .out_ready (hsel_ready)
    );

    rs_decode u_decode (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_data   (hsel_data),
        .in_valid  (hsel_valid),
        .in_ready  (hsel_ready),
        .out_data  (dec_out),
        .out_valid (dec_out_valid),
        .out_ready (dec_out_ready)
    );

endmodule

`default_nettype wire

// File: test/rs_erasure_codec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rs_erasure_codec_tb;

    import fec_pkg::*;

    localparam int timeout_cycles = 200;

    logic     clk;
    logic     arst_n;
    enc_in_t  enc_in;
    logic     enc_in_valid;
    logic     enc_in_ready;
    enc_out_t enc_out;
    logic     enc_out_valid;
    logic     enc_out_ready;
    dec_in_t  dec_in;
    logic     dec_in_valid;
    logic     dec_in_ready;
    dec_out_t dec_out;
    logic     dec_out_valid;
    logic     dec_out_ready;

    // Stimulus and the results still owed in order
    enc_in_t  enc_stim[$];
    cw_t      enc_exp[$];
    msg_t     enc_msg[$];
    dec_in_t  dec_stim[$];
    msg_t     dec_exp[$];

    int cyc            = 0;
    int enc_seen       = 0;
    int dec_seen       = 0;
    int enc_accept_cyc = -1;
    int dec_accept_cyc = -1;

    rs_erasure_codec u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Random output stalls once the first result of a path is through
    always @(posedge clk) begin
        #1;
        enc_out_ready = (enc_seen == 0) || ($urandom_range(3) != 0);
        dec_out_ready = (dec_seen == 0) || ($urandom_range(3) != 0);
    end

    // ==================================================
    // Error reporting and compares
    // ==================================================

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_codeword(input string name, input cw_t expected, input cw_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_message(input string name, input msg_t expected, input msg_t actual);
        if (actual !== expected) begin
            stop_on_error($sformatf("FAILED %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected) begin
            stop_on_error($sformatf("FAILED %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    // ==================================================
    // Vector file
    // ==================================================

    task automatic load_vectors();
        int               fd;
        int               code;
        logic [63:0]      kind;
        logic [8*128-1:0] rest;
        msg_t             m;
        cw_t              cw;
        h_idx_t           h;
        cw_t              rx;
        enc_in_t          e;
        dec_in_t          d;
        fd = $fopen("test/rs_testdata.txt", "r");
        if (fd == 0) begin
            stop_on_error("could not open test/rs_testdata.txt");
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind[7:0] == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h %h %h", m, cw, h, rx);
                if (code != 4) begin
                    stop_on_error("a line of the test data could not be parsed");
                end
                if (kind[7:0] == "E") begin
                    e.msg = m;
                    enc_stim.push_back(e);
                    enc_exp.push_back(cw);
                    enc_msg.push_back(m);
                end else begin
                    d.cw    = rx;
                    d.h_idx = h;
                    dec_stim.push_back(d);
                    dec_exp.push_back(m);
                end
            end
        end
        $fclose(fd);
    endtask

    // ==================================================
    // Drivers and output monitors
    // ==================================================

    task automatic drive_enc();
        int wait_cyc;
        while (enc_stim.size() > 0) begin
            enc_in       = enc_stim.pop_front();
            enc_in_valid = 1'b1;
            wait_cyc     = 0;
            @(negedge clk);
            while (!enc_in_ready) begin
                wait_cyc++;
                if (wait_cyc > timeout_cycles) stop_on_error("timeout waiting for enc_in_ready");
                @(negedge clk);
            end
            if (enc_accept_cyc < 0) enc_accept_cyc = cyc;
            @(posedge clk);
            #1;
        end
        enc_in_valid = 1'b0;
    endtask

    task automatic drive_dec();
        int wait_cyc;
        while (dec_stim.size() > 0) begin
            dec_in       = dec_stim.pop_front();
            dec_in_valid = 1'b1;
            wait_cyc     = 0;
            @(negedge clk);
            while (!dec_in_ready) begin
                wait_cyc++;
                if (wait_cyc > timeout_cycles) stop_on_error("timeout waiting for dec_in_ready");
                @(negedge clk);
            end
            if (dec_accept_cyc < 0) dec_accept_cyc = cyc;
            @(posedge clk);
            #1;
        end
        dec_in_valid = 1'b0;
    endtask

    task automatic watch_enc();
        int  idle;
        bit  stalled;
        cw_t held;
        idle    = 0;
        stalled = 1'b0;
        while (enc_exp.size() > 0) begin
            @(negedge clk);
            if (stalled) begin
                if (!enc_out_valid) stop_on_error("enc_out_valid dropped while stalled");
                check_codeword("enc hold", held, enc_out.cw);
            end
            stalled = enc_out_valid && !enc_out_ready;
            held    = enc_out.cw;
            if (enc_out_valid && enc_out_ready) begin
                if (enc_seen == 0) check_count("enc latency", 1, cyc - enc_accept_cyc);
                // Data symbols against the stimulus, then the parity from the file
                check_message("enc data symbols", enc_msg.pop_front(), enc_out.cw[rs_k-1:0]);
                check_codeword("enc codeword", enc_exp.pop_front(), enc_out.cw);
                enc_seen++;
                idle = 0;
            end else begin
                idle++;
                if (idle > timeout_cycles) stop_on_error("timeout waiting for an encoder result");
            end
        end
    endtask

    task automatic watch_dec();
        int   idle;
        bit   stalled;
        msg_t held;
        idle    = 0;
        stalled = 1'b0;
        while (dec_exp.size() > 0) begin
            @(negedge clk);
            if (stalled) begin
                if (!dec_out_valid) stop_on_error("dec_out_valid dropped while stalled");
                check_message("dec hold", held, dec_out.msg);
            end
            stalled = dec_out_valid && !dec_out_ready;
            held    = dec_out.msg;
            if (dec_out_valid && dec_out_ready) begin
                if (dec_seen == 0) check_count("dec latency", 2, cyc - dec_accept_cyc);
                check_message($sformatf("dec result %0d", dec_seen), dec_exp.pop_front(),
                              dec_out.msg);
                dec_seen++;
                idle = 0;
            end else begin
                idle++;
                if (idle > timeout_cycles) stop_on_error("timeout waiting for a decoder result");
            end
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        void'($urandom(13240));
        arst_n        = 1'b0;
        enc_in        = '0;
        enc_in_valid  = 1'b0;
        enc_out_ready = 1'b1;
        dec_in        = '0;
        dec_in_valid  = 1'b0;
        dec_out_ready = 1'b1;
        load_vectors();
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        @(negedge clk);
        if (enc_out_valid !== 1'b0 || dec_out_valid !== 1'b0) begin
            stop_on_error("an output valid is not low after reset");
        end
        if (enc_in_ready !== 1'b1 || dec_in_ready !== 1'b1) begin
            stop_on_error("an input ready is not high after reset");
        end
        @(posedge clk);
        #1;
        // Both streams at once
        fork
            drive_enc();
            drive_dec();
            watch_enc();
            watch_dec();
        join
        // Anything further would be a duplicate
        repeat (4) begin
            @(negedge clk);
            if (enc_out_valid || dec_out_valid) begin
                stop_on_error("output valid after the last result");
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/rs_testdata.txt
# kind (E encode, D decode) message codeword erasure_index received_word
E 1234 241234 0 000000
E a5c7 44a5c7 0 000000
E ffff a0ffff 0 000000
E 6b18 546b18 0 000000
D 1234 241234 0 2412de
D a5c7 44a5c7 1 44a0c0
D ffff a0ffff 2 a03ff5
D 0e09 470e09 3 4f0e06
D 6b18 546b18 4 946b12
D 1234 241234 5 241884
D a5c7 44a5c7 6 441527
D ffff a0ffff 7 acff3f
D 0e09 470e09 8 b70ed9
D 6b18 546b18 9 540018
D 1234 241234 a 271634
D a5c7 44a5c7 b e4a9c7
D ffff a0ffff c a51fff
D 0e09 470e09 d 17ce09
D 6b18 546b18 e 006b18
